// File: Makefile
VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/frontend_tb.sv
// Instruction frontend testbench
`timescale 1ns/100ps
`default_nettype none

module frontend_tb import frontend_pkg::*; ();

  typedef struct {
    logic        flush;
    logic        wait_req;
    logic [31:0] target;
    int          ready_thr;
    int          count;
  } scenario_t;

  logic                                   clk;
  logic                                   rst_n;
  logic                                   flush;
  logic [XLEN-1:0]                        redirect_pc;
  logic                                   imem_req;
  logic [XLEN-1:0]                        imem_addr;
  logic                                   imem_rsp_valid;
  logic [IMEM_DATA_W-1:0]                 imem_rsp_data;
  logic                                   dec_ready;
  logic [DECODE_WIDTH-1:0]                dec_valid;
  logic [DECODE_WIDTH-1:0][XLEN-1:0]      dec_vaddr;
  inst_class_e [DECODE_WIDTH-1:0]         dec_class;
  logic [DECODE_WIDTH-1:0][OPERAND_W-1:0] dec_operand;

  scenario_t       rows [8];
  logic            rows_loaded = 1'b0;
  logic [31:0]     rand_state;
  logic [XLEN-1:0] exp_vaddr;
  int              accepted;
  int              class_seen [8];
  logic            req_open;

  // Snapshot of the outputs while the core stalls
  logic                                   hold_armed;
  logic [DECODE_WIDTH-1:0]                snap_valid;
  logic [DECODE_WIDTH-1:0][XLEN-1:0]      snap_vaddr;
  inst_class_e [DECODE_WIDTH-1:0]         snap_class;
  logic [DECODE_WIDTH-1:0][OPERAND_W-1:0] snap_operand;

  frontend_top u_dut (
    .clk              (clk),
    .rst_n_i          (rst_n),
    .flush_i          (flush),
    .redirect_pc_i    (redirect_pc),
    .imem_req_o       (imem_req),
    .imem_addr_o      (imem_addr),
    .imem_rsp_valid_i (imem_rsp_valid),
    .imem_rsp_data_i  (imem_rsp_data),
    .dec_ready_i      (dec_ready),
    .dec_valid_o      (dec_valid),
    .dec_vaddr_o      (dec_vaddr),
    .dec_class_o      (dec_class),
    .dec_operand_o    (dec_operand)
  );

  imem_model u_imem (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .req_i       (imem_req),
    .addr_i      (imem_addr),
    .rsp_valid_o (imem_rsp_valid),
    .rsp_data_o  (imem_rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ====================
  // Reference helpers
  // ====================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return xorshift32(xorshift32(addr));
  endfunction

  function automatic inst_class_e expected_class(input logic [31:0] word);
    inst_class_e cls;
    if (word[29:26] == 4'hf) begin
      cls = CLS_ILLEGAL;
    end else begin
      case (word[31:30])
        2'b00:   cls = CLS_ALU;
        2'b01:   cls = CLS_LOAD;
        2'b10:   cls = CLS_STORE;
        default: cls = CLS_BRANCH;
      endcase
    end
    return cls;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic set_row(input int idx, input logic fl, input logic wr,
                         input logic [31:0] target, input int thr, input int count);
    rows[idx].flush     = fl;
    rows[idx].wait_req  = wr;
    rows[idx].target    = target;
    rows[idx].ready_thr = thr;
    rows[idx].count     = count;
  endtask

  // Columns are flush, flush during a fetch, redirect, ready odds out of 256 and count
  task automatic load_rows();
    set_row(0, 1'b0, 1'b0, 32'h0000_0000, 256, 40);
    set_row(1, 1'b0, 1'b0, 32'h0000_0000, 128, 40);
    set_row(2, 1'b0, 1'b0, 32'h0000_0000,  40, 30);
    set_row(3, 1'b1, 1'b0, 32'h1c00_4000, 256, 24);
    set_row(4, 1'b1, 1'b0, 32'h1c00_8004, 128, 24);
    set_row(5, 1'b1, 1'b1, 32'h1c01_0000, 256, 24);
    set_row(6, 1'b1, 1'b1, 32'h1c02_000c,  96, 30);
    set_row(7, 1'b0, 1'b0, 32'h0000_0000, 256, 20);
  endtask

  // ====================
  // Scoreboard
  // ====================
  task automatic score_outputs();
    logic [31:0] word;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      if (dec_valid[i]) begin
        word = word_at(exp_vaddr);
        check_value($sformatf("dec_vaddr_o[%0d]", i), dec_vaddr[i], exp_vaddr);
        check_value($sformatf("dec_class_o[%0d]", i), 32'(dec_class[i]),
                    32'(expected_class(word)));
        check_value($sformatf("dec_operand_o[%0d]", i), 32'(dec_operand[i]),
                    {6'd0, word[25:0]});
        class_seen[int'(dec_class[i])] = class_seen[int'(dec_class[i])] + 1;
        exp_vaddr = exp_vaddr + 32'd4;
        accepted  = accepted + 1;
      end
    end
  endtask

  task automatic check_hold();
    check_value("dec_valid_o while stalled", 32'(dec_valid), 32'(snap_valid));
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      if (snap_valid[i]) begin
        check_value($sformatf("dec_vaddr_o[%0d] while stalled", i),
                    dec_vaddr[i], snap_vaddr[i]);
        check_value($sformatf("dec_class_o[%0d] while stalled", i),
                    32'(dec_class[i]), 32'(snap_class[i]));
        check_value($sformatf("dec_operand_o[%0d] while stalled", i),
                    32'(dec_operand[i]), 32'(snap_operand[i]));
      end
    end
  endtask

  // Drive ready on a negedge and score what the next posedge accepts
  task automatic step_cycle(input int thr);
    logic ready;
    if (hold_armed) begin
      check_hold();
    end
    rand_state = xorshift32(rand_state);
    ready      = int'(rand_state[7:0]) < thr;
    dec_ready  = ready;
    if (ready) begin
      score_outputs();
    end
    if (!ready && (dec_valid != '0)) begin
      snap_valid   = dec_valid;
      snap_vaddr   = dec_vaddr;
      snap_class   = dec_class;
      snap_operand = dec_operand;
      hold_armed   = 1'b1;
    end else begin
      hold_armed = 1'b0;
    end
  endtask

  task automatic issue_flush(input logic [31:0] target);
    flush       = 1'b1;
    redirect_pc = target;
    dec_ready   = 1'b0;
    hold_armed  = 1'b0;
    exp_vaddr   = {target[31:2], 2'b00};
    @(negedge clk);
    flush = 1'b0;
  endtask

  task automatic run_row(input int r);
    int goal;
    if (rows[r].flush) begin
      @(negedge clk);
      // Wait for a request in flight so the flush makes it stale
      while (rows[r].wait_req && !imem_req) begin
        step_cycle(rows[r].ready_thr);
        @(negedge clk);
      end
      issue_flush(rows[r].target);
    end
    goal = accepted + rows[r].count;
    while (accepted < goal) begin
      @(negedge clk);
      step_cycle(rows[r].ready_thr);
    end
  endtask

  // Group addresses stay aligned and only one request is in flight
  always @(posedge clk) begin
    if (!rst_n) begin
      req_open = 1'b0;
    end else if (imem_req) begin
      check_value("imem_addr_o[2:0]", 32'(imem_addr[2:0]), 32'd0);
      if (req_open) begin
        $display("Memory request issued while another was still outstanding");
        $display("Simulation finished: FAIL");
        $fatal(1, "overlapping requests");
      end
      req_open = 1'b1;
    end else if (imem_rsp_valid) begin
      req_open = 1'b0;
    end
  end

  // ====================
  // Main sequence
  // ====================
  initial begin
    logic missing;
    rst_n       = 1'b0;
    flush       = 1'b0;
    redirect_pc = '0;
    dec_ready   = 1'b0;
    rand_state  = 32'h29c4_0ede;
    exp_vaddr   = RESET_PC;
    accepted    = 0;
    hold_armed  = 1'b0;
    for (int c = 0; c < 8; c++) begin
      class_seen[c] = 0;
    end
    load_rows();
    rows_loaded = 1'b1;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    check_value("imem_req_o", 32'(imem_req), 32'd0);
    check_value("dec_valid_o", 32'(dec_valid), 32'd0);
    for (int r = 0; r < $size(rows); r++) begin
      run_row(r);
    end
    missing = 1'b0;
    for (int c = 0; c < 8; c++) begin
      if ((c <= int'(CLS_BRANCH) || c == int'(CLS_ILLEGAL)) && class_seen[c] == 0) begin
        $display("Instruction class %0d never reached the decode outputs", c);
        missing = 1'b1;
      end
    end
    if (missing) begin
      $display("Simulation finished: FAIL");
      $fatal(1, "class coverage incomplete");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

  // Watchdog sized from the scenario counts
  initial begin
    int limit;
    wait (rows_loaded);
    limit = 16;
    for (int r = 0; r < $size(rows); r++) begin
      limit = limit + rows[r].count * 20;
    end
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles before all scenarios completed", limit);
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: bench/imem_model.sv
// Instruction memory model
`timescale 1ns/100ps
`default_nettype none

module imem_model import frontend_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   req_i,
  input  logic [XLEN-1:0]        addr_i,
  output logic                   rsp_valid_o,
  output logic [IMEM_DATA_W-1:0] rsp_data_o
);

  logic [31:0]     rand_state;
  logic [XLEN-1:0] pend_addr;
  logic            busy;
  int              wait_cnt;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Memory word is a hash of the full address
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return xorshift32(xorshift32(addr));
  endfunction

  initial begin
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    rand_state  = 32'h29c4_0ede;
    pend_addr   = '0;
    busy        = 1'b0;
    wait_cnt    = 0;
    forever begin
      @(negedge clk);
      rsp_valid_o = 1'b0;
      if (!rst_n_i) begin
        busy = 1'b0;
      end else if (busy) begin
        wait_cnt = wait_cnt - 1;
        if (wait_cnt == 0) begin
          rsp_valid_o = 1'b1;
          rsp_data_o  = {word_at(pend_addr + 32'd4), word_at(pend_addr)};
          busy        = 1'b0;
        end
      end else if (req_i) begin
        // Latency of 1 to 4 cycles
        rand_state = xorshift32(rand_state);
        wait_cnt   = 1 + int'(rand_state[1:0]);
        pend_addr  = addr_i;
        busy       = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
// Decode stage with output register
`timescale 1ns/100ps
`default_nettype none

module decode_stage import frontend_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  input  logic [DECODE_WIDTH-1:0] ibuf_valid_i,
  input  ibuf_entry_t             ibuf_data_i [DECODE_WIDTH],
  output logic [DECODE_NUM_W-1:0] ibuf_num_o,
  output logic                    ibuf_pop_o,
  input  logic                    dec_ready_i,
  output dec_info_t               dec_o [DECODE_WIDTH]
);

  inst_class_e slot_cls [DECODE_WIDTH];
  dec_info_t   dec_d    [DECODE_WIDTH];
  dec_info_t   dec_q    [DECODE_WIDTH];
  logic        any_valid;
  logic        load;

  for (genvar g = 0; g < DECODE_WIDTH; g++) begin : g_dec
    inst_decoder u_dec (
      .inst_i  (ibuf_data_i[g].inst),
      .class_o (slot_cls[g])
    );
  end

  always_comb begin
    ibuf_num_o = '0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      ibuf_num_o         = ibuf_num_o + DECODE_NUM_W'(ibuf_valid_i[i]);
      dec_d[i].valid     = ibuf_valid_i[i];
      dec_d[i].vaddr     = ibuf_data_i[i].vaddr;
      dec_d[i].cls       = slot_cls[i];
      dec_d[i].operand   = ibuf_data_i[i].inst[OPERAND_W-1:0];
    end
  end

  // Register takes new work when empty or drained this cycle
  always_comb begin
    any_valid = 1'b0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      any_valid = any_valid | dec_q[i].valid;
    end
  end

  assign load       = !any_valid || dec_ready_i;
  assign ibuf_pop_o = load;

  always_ff @(posedge clk) begin
    if (!rst_n_i || flush_i) begin
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        dec_q[i].valid <= 1'b0;
      end
    end else if (load) begin
      dec_q <= dec_d;
    end
  end

  assign dec_o = dec_q;

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
// Instruction fetch unit
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import frontend_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  input  logic                   faq_valid_i,
  input  logic [XLEN-1:0]        faq_pc_i,
  output logic                   faq_pop_o,
  output logic                   imem_req_o,
  output logic [XLEN-1:0]        imem_addr_o,
  input  logic                   imem_rsp_valid_i,
  input  logic [IMEM_DATA_W-1:0] imem_rsp_data_i,
  ibuf_wr_if.producer            ibuf
);

  typedef enum logic {FU_IDLE, FU_WAIT} fu_state_e;

  fu_state_e        state_q;
  logic             stale_q;
  logic             req_q;
  logic [XLEN-1:0]  addr_q;
  logic             issue;
  logic [XLEN-1:0]  group_base;
  logic [SLOT_W-1:0] slot_ofs;
  logic [FETCH_NUM_W-1:0] wr_num;

  // Room for a full group is checked before the request leaves
  assign issue = (state_q == FU_IDLE) && faq_valid_i && ibuf.ready && !flush_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= FU_IDLE;
      stale_q <= 1'b0;
      req_q   <= 1'b0;
    end else begin
      req_q <= issue;
      case (state_q)
        FU_IDLE: begin
          if (issue) begin
            state_q <= FU_WAIT;
          end
        end
        FU_WAIT: begin
          if (imem_rsp_valid_i) begin
            state_q <= FU_IDLE;
            stale_q <= 1'b0;
          end else if (flush_i) begin
            // Response still due so drop it when it shows up
            stale_q <= 1'b1;
          end
        end
        default: state_q <= FU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      addr_q <= faq_pc_i;
    end
  end

  assign group_base  = {addr_q[XLEN-1:GROUP_OFS_W], {GROUP_OFS_W{1'b0}}};
  assign slot_ofs    = addr_q[GROUP_OFS_W-1:2];
  assign imem_req_o  = req_q;
  assign imem_addr_o = group_base;

  // Slot i takes word i + offset of the response
  always_comb begin
    int src;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      src = i + int'(slot_ofs);
      ibuf.data[i] = '0;
      if (src < FETCH_WIDTH) begin
        ibuf.data[i].inst  = imem_rsp_data_i[src*XLEN +: XLEN];
        ibuf.data[i].vaddr = group_base + XLEN'(src * 4);
      end
    end
  end

  assign wr_num     = FETCH_NUM_W'(FETCH_WIDTH) - FETCH_NUM_W'(slot_ofs);
  assign ibuf.num   = wr_num;
  assign ibuf.valid = (state_q == FU_WAIT) && imem_rsp_valid_i && !stale_q && !flush_i;
  assign faq_pop_o  = ibuf.valid && ibuf.ready;

endmodule

`default_nettype wire

// File: hw/frontend_pkg.sv
// Instruction frontend definitions
`default_nettype none

package frontend_pkg;

  // ====================
  // Core widths and sizes
  // ====================
  localparam int XLEN         = 32;
  localparam int FETCH_WIDTH  = 2;
  localparam int DECODE_WIDTH = 2;
  localparam int FAQ_DEPTH    = 4;
  localparam int IBUF_DEPTH   = 8;

  localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

  // Derived from the fetch group size
  localparam int FETCH_BYTES  = FETCH_WIDTH * 4;
  localparam int GROUP_OFS_W  = $clog2(FETCH_BYTES);
  localparam int SLOT_W       = $clog2(FETCH_WIDTH);
  localparam int IMEM_DATA_W  = FETCH_WIDTH * XLEN;
  localparam int FETCH_NUM_W  = $clog2(FETCH_WIDTH + 1);
  localparam int DECODE_NUM_W = $clog2(DECODE_WIDTH + 1);
  localparam int OPERAND_W    = 26;

  // ====================
  // Types
  // ====================
  // One fetched instruction and where it came from
  typedef struct packed {
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] vaddr;
  } ibuf_entry_t;

  typedef enum logic [2:0] {
    CLS_ALU     = 3'd0,
    CLS_LOAD    = 3'd1,
    CLS_STORE   = 3'd2,
    CLS_BRANCH  = 3'd3,
    CLS_ILLEGAL = 3'd7
  } inst_class_e;

  // Decode register slot
  typedef struct packed {
    logic                 valid;
    logic [XLEN-1:0]      vaddr;
    inst_class_e          cls;
    logic [OPERAND_W-1:0] operand;
  } dec_info_t;

endpackage

`default_nettype wire

// File: hw/frontend_top.sv
// Instruction frontend top level
`timescale 1ns/100ps
`default_nettype none

module frontend_top import frontend_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic                                  flush_i,
  input  logic [XLEN-1:0]                       redirect_pc_i,
  output logic                                  imem_req_o,
  output logic [XLEN-1:0]                       imem_addr_o,
  input  logic                                  imem_rsp_valid_i,
  input  logic [IMEM_DATA_W-1:0]                imem_rsp_data_i,
  input  logic                                  dec_ready_i,
  output logic [DECODE_WIDTH-1:0]               dec_valid_o,
  output logic [DECODE_WIDTH-1:0][XLEN-1:0]     dec_vaddr_o,
  output inst_class_e [DECODE_WIDTH-1:0]        dec_class_o,
  output logic [DECODE_WIDTH-1:0][OPERAND_W-1:0] dec_operand_o
);

  // ====================
  // Next PC and address queue
  // ====================
  logic            push_valid;
  logic            push_ready;
  logic [XLEN-1:0] push_pc;
  logic [0:0]      faq_valid;
  logic [XLEN-1:0] faq_head [1];
  logic            faq_pop;

  ibuf_wr_if #(.DATA_T(logic [XLEN-1:0]), .WPORTS(1)) faq_wr ();

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .redirect_pc_i (redirect_pc_i),
    .push_ready_i  (push_ready),
    .push_valid_o  (push_valid),
    .push_pc_o     (push_pc)
  );

  assign faq_wr.valid   = push_valid;
  assign faq_wr.num     = 1'b1;
  assign faq_wr.data[0] = push_pc;
  assign push_ready     = faq_wr.ready;

  sync_multi_fifo #(
    .DATA_T (logic [XLEN-1:0]),
    .DEPTH  (FAQ_DEPTH),
    .WPORTS (1),
    .RPORTS (1)
  ) u_faq (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .wr           (faq_wr.consumer),
    .read_valid_o (faq_valid),
    .read_data_o  (faq_head),
    .read_num_i   (1'b1),
    .read_ready_i (faq_pop)
  );

  // ====================
  // Fetch and instruction buffer
  // ====================
  logic [DECODE_WIDTH-1:0] ibuf_valid;
  ibuf_entry_t             ibuf_data [DECODE_WIDTH];
  logic [DECODE_NUM_W-1:0] ibuf_num;
  logic                    ibuf_pop;
  dec_info_t               dec_q [DECODE_WIDTH];

  ibuf_wr_if #(.DATA_T(ibuf_entry_t), .WPORTS(FETCH_WIDTH)) ibuf_wr ();

  fetch_unit u_fetch (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .faq_valid_i      (faq_valid[0]),
    .faq_pc_i         (faq_head[0]),
    .faq_pop_o        (faq_pop),
    .imem_req_o       (imem_req_o),
    .imem_addr_o      (imem_addr_o),
    .imem_rsp_valid_i (imem_rsp_valid_i),
    .imem_rsp_data_i  (imem_rsp_data_i),
    .ibuf             (ibuf_wr.producer)
  );

  sync_multi_fifo #(
    .DATA_T (ibuf_entry_t),
    .DEPTH  (IBUF_DEPTH),
    .WPORTS (FETCH_WIDTH),
    .RPORTS (DECODE_WIDTH)
  ) u_ibuf (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .wr           (ibuf_wr.consumer),
    .read_valid_o (ibuf_valid),
    .read_data_o  (ibuf_data),
    .read_num_i   (ibuf_num),
    .read_ready_i (ibuf_pop)
  );

  decode_stage u_decode (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .ibuf_valid_i (ibuf_valid),
    .ibuf_data_i  (ibuf_data),
    .ibuf_num_o   (ibuf_num),
    .ibuf_pop_o   (ibuf_pop),
    .dec_ready_i  (dec_ready_i),
    .dec_o        (dec_q)
  );

  // Per-slot fields out to plain ports
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      dec_valid_o[i]   = dec_q[i].valid;
      dec_vaddr_o[i]   = dec_q[i].vaddr;
      dec_class_o[i]   = dec_q[i].cls;
      dec_operand_o[i] = dec_q[i].operand;
    end
  end

endmodule

`default_nettype wire

// File: hw/ibuf_wr_if.sv
// Multi-slot FIFO write bundle
`timescale 1ns/100ps
`default_nettype none

interface ibuf_wr_if #(
  parameter type DATA_T = logic [31:0],
  parameter int  WPORTS = 2
);

  logic                          valid;
  logic [$clog2(WPORTS+1)-1:0]   num;
  DATA_T                         data [WPORTS];
  logic                          ready;

  // The num entries sit in the low slots
  modport producer (output valid, output num, output data, input ready);
  modport consumer (input valid, input num, input data, output ready);

endinterface

`default_nettype wire

// File: hw/inst_decoder.sv
// Single instruction classifier
`timescale 1ns/100ps
`default_nettype none

module inst_decoder import frontend_pkg::*; (
  input  logic [XLEN-1:0] inst_i,
  output inst_class_e     class_o
);

  logic reserved;

  // Bits 29..26 all set is a reserved encoding
  assign reserved = &inst_i[29:26];

  always_comb begin
    if (reserved) begin
      class_o = CLS_ILLEGAL;
    end else begin
      case (inst_i[31:30])
        2'b00:   class_o = CLS_ALU;
        2'b01:   class_o = CLS_LOAD;
        2'b10:   class_o = CLS_STORE;
        default: class_o = CLS_BRANCH;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/pc_gen.sv
// Sequential fetch address generator
`timescale 1ns/100ps
`default_nettype none

module pc_gen import frontend_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            flush_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  input  logic            push_ready_i,
  output logic            push_valid_o,
  output logic [XLEN-1:0] push_pc_o
);

  logic [XLEN-1:0] pc_q;
  logic            valid_q;
  logic [XLEN-1:0] group_base;

  // Next group always starts on an 8-byte boundary
  assign group_base = {pc_q[XLEN-1:GROUP_OFS_W], {GROUP_OFS_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q    <= RESET_PC;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
      if (flush_i) begin
        // Word offset kept so the fetch unit can skip the low slot
        pc_q <= {redirect_pc_i[XLEN-1:2], 2'b00};
      end else if (valid_q && push_ready_i) begin
        pc_q <= group_base + XLEN'(FETCH_BYTES);
      end
    end
  end

  assign push_valid_o = valid_q;
  assign push_pc_o    = pc_q;

endmodule

`default_nettype wire

// File: hw/sync_multi_fifo.sv
// Multi-port synchronous FIFO
`timescale 1ns/100ps
`default_nettype none

module sync_multi_fifo #(
  parameter type DATA_T = logic [31:0],
  parameter int  DEPTH  = 8,
  parameter int  WPORTS = 2,
  parameter int  RPORTS = 2
) (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        flush_i,
  ibuf_wr_if.consumer                 wr,
  output logic [RPORTS-1:0]           read_valid_o,
  output DATA_T                       read_data_o [RPORTS],
  input  logic [$clog2(RPORTS+1)-1:0] read_num_i,
  input  logic                        read_ready_i
);

  // Pointers wrap on their own since DEPTH is a power of two
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  DATA_T            mem [DEPTH];
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;

  logic             do_push;
  logic [CNT_W-1:0] push_cnt;
  logic [CNT_W-1:0] pop_cnt;

  // ====================
  // Handshake and counts
  // ====================
  assign wr.ready = (DEPTH - int'(count_q)) >= WPORTS;
  assign do_push  = wr.valid && wr.ready;
  assign push_cnt = do_push ? CNT_W'(wr.num) : '0;

  always_comb begin
    pop_cnt = '0;
    if (read_ready_i) begin
      if (CNT_W'(read_num_i) > count_q) begin
        pop_cnt = count_q;
      end else begin
        pop_cnt = CNT_W'(read_num_i);
      end
    end
  end

  // ====================
  // Pointers
  // ====================
  always_ff @(posedge clk) begin
    if (!rst_n_i || flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      head_q  <= head_q + PTR_W'(pop_cnt);
      tail_q  <= tail_q + PTR_W'(push_cnt);
      count_q <= count_q + push_cnt - pop_cnt;
    end
  end

  // Storage written in consecutive slots from the tail
  always_ff @(posedge clk) begin
    for (int i = 0; i < WPORTS; i++) begin
      if (do_push && (i < int'(wr.num))) begin
        mem[tail_q + PTR_W'(i)] <= wr.data[i];
      end
    end
  end

  // ====================
  // Read side
  // ====================
  always_comb begin
    for (int i = 0; i < RPORTS; i++) begin
      read_valid_o[i] = int'(count_q) > i;
      read_data_o[i]  = mem[head_q + PTR_W'(i)];
    end
  end

endmodule

`default_nettype wire

// File: list.f
hw/frontend_pkg.sv
hw/ibuf_wr_if.sv
hw/pc_gen.sv
hw/sync_multi_fifo.sv
hw/fetch_unit.sv
hw/inst_decoder.sv
hw/decode_stage.sv
hw/frontend_top.sv
bench/imem_model.sv
bench/frontend_tb.sv
